/* logic/pattern_checker.sv */
// pattern_checker: hunt/track FSM, expected word build, byte-masked compare
`timescale 1ns/1ps
`default_nettype none

`include "radio_sink_defs.svh"

module pattern_checker (
  input  wire logic        s_sink_aclk,
  input  wire logic        rst,
  input  wire logic        enable,

  // captured beats from the input side
  sink_beat_if.beat_in     beat_bus,

  // judged beats towards the status counters
  check_result_if.result_out result_bus
);

  import radio_sink_pkg::*;

  chk_state_t   state;
  pat_cnt_t     pat_cnt;
  sample_word_t expect_word;
  byte_keep_t   byte_bad;
  logic         miss;

  // ------------------------------
  // expected word
  // ------------------------------

  // marker, slot, marker in the top 16 bits
  // then the running count repeated three times
  assign expect_word = {`RS_MARK_NIBBLE, beat_bus.slot, `RS_MARK_NIBBLE,
                        pat_cnt, pat_cnt, pat_cnt};

  // ------------------------------
  // byte compare
  // ------------------------------

  // a byte only counts when its keep bit is set
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      byte_bad[i] = beat_bus.keep[i] &&
                    (beat_bus.data[8*i +: 8] != expect_word[8*i +: 8]);
    end
  end

  // any enabled byte off the pattern fails the whole beat
  assign miss = |byte_bad;

  // ------------------------------
  // lock FSM
  // ------------------------------

  always_ff @(posedge s_sink_aclk) begin
    if (rst || !enable) begin
      state               <= CHK_HUNT;
      result_bus.done     <= 1'b0;
      result_bus.mismatch <= 1'b0;
    end else begin
      // every beat gets a done, locked or not
      result_bus.done     <= beat_bus.beat;
      result_bus.mismatch <= 1'b0;
      if (beat_bus.beat) begin
        case (state)
          CHK_HUNT: begin
            // first beat seeds the count, never judged
            state <= CHK_TRACK;
          end
          CHK_TRACK: begin
            if (miss) begin
              // drop lock, next beat reseeds from its own data
              result_bus.mismatch <= 1'b1;
              state               <= CHK_HUNT;
            end
          end
          default: state <= CHK_HUNT;
        endcase
      end
    end
  end

  // ------------------------------
  // running count
  // ------------------------------

  // seeded from the low 16 bits of the hunt beat, plus one for the next beat
  // held on a mismatch, the hunt that follows loads it anyway
  always_ff @(posedge s_sink_aclk) begin
    if (beat_bus.beat) begin
      if (state == CHK_HUNT) begin
        pat_cnt <= beat_bus.data[15:0] + pat_cnt_t'(1);
      end else if (!miss) begin
        pat_cnt <= pat_cnt + pat_cnt_t'(1);
      end
    end
  end

  // packet end and symbol flags ride along with done
  always_ff @(posedge s_sink_aclk) begin
    if (beat_bus.beat) begin
      result_bus.last <= beat_bus.last;
      result_bus.sosy <= beat_bus.sosy;
    end
  end

  // lock is simply the tracking state
  assign result_bus.locked = (state == CHK_TRACK);

endmodule

`default_nettype wire

/* logic/radio_sink_defs.svh */
// radio sink constants: pattern marker nibble, error counter width, tuser sosy bit
`ifndef RADIO_SINK_DEFS_SVH
`define RADIO_SINK_DEFS_SVH

// ------------------------------
// test pattern
// ------------------------------

// marker nibble on each side of the slot number in the top 16 bits
`define RS_MARK_NIBBLE 4'hA

// ------------------------------
// status counters
// ------------------------------

// error count width, counter stops once its top bit is set
`define RS_ERR_W 16

// ------------------------------
// tuser layout
// ------------------------------

// start of symbol flag in the 31-bit section tuser
`define RS_SOSY_BIT 27

`endif

/* logic/radio_sink_ifs.sv */
// radio sink interfaces: captured beat bus and checker result bus with modports
`timescale 1ns/1ps
`default_nettype none

// ------------------------------
// capture -> checker
// ------------------------------

interface sink_beat_if;
  import radio_sink_pkg::*;

  // one cycle strobe per accepted beat
  logic         beat;
  // beat payload, stable from the strobe until the next accepted beat
  sample_word_t data;
  byte_keep_t   keep;
  logic         last;
  // start of symbol bit lifted out of tuser
  logic         sosy;
  // slot as sampled together with the beat
  slot_t        slot;

  // capture side drives everything
  modport beat_out (output beat, data, keep, last, sosy, slot);
  // checker side only reads
  modport beat_in (input beat, data, keep, last, sosy, slot);

endinterface

// ------------------------------
// checker -> status
// ------------------------------

interface check_result_if;

  // level, high while the checker tracks the pattern
  logic locked;
  // one cycle strobe per judged beat
  logic done;
  // high with done when the beat failed the compare
  logic mismatch;
  // packet end and start of symbol carried along with done
  logic last;
  logic sosy;

  modport result_out (output locked, done, mismatch, last, sosy);
  modport result_in (input locked, done, mismatch, last, sosy);

endinterface

`default_nettype wire

/* logic/radio_sink_pkg.sv */
// radio sink package: stream field types, counter types and checker state enum
`default_nettype none

`include "radio_sink_defs.svh"

package radio_sink_pkg;

  // ------------------------------
  // stream fields
  // ------------------------------

  // one 64-bit sample beat
  typedef logic [63:0] sample_word_t;
  // byte enables, bit i covers data byte i
  typedef logic [7:0] byte_keep_t;
  // section tuser as delivered by the de-framer
  typedef logic [30:0] sec_user_t;
  // slot number sampled with each beat
  typedef logic [7:0] slot_t;

  // ------------------------------
  // counters and state
  // ------------------------------

  // running count repeated three times in the pattern word
  typedef logic [15:0] pat_cnt_t;
  // saturating data error count
  typedef logic [`RS_ERR_W-1:0] err_cnt_t;
  // packet end and start of symbol counts, both wrap
  typedef logic [7:0] pkt_cnt_t;

  // hunt waits for a beat to lock on, track compares every beat
  typedef enum logic {
    CHK_HUNT,
    CHK_TRACK
  } chk_state_t;

endpackage

`default_nettype wire

/* logic/radio_sink_top.sv */
// radio_sink_top: radio sink check block, capture, checker and status stages
`timescale 1ns/1ps
`default_nettype none

module radio_sink_top (
  input  wire logic                         s_sink_aclk,
  input  wire logic                         rst,

  // ------------------------------
  // sample stream
  // ------------------------------
  input  wire radio_sink_pkg::sample_word_t tdata,
  input  wire radio_sink_pkg::byte_keep_t   tkeep,
  input  wire logic                         tvalid,
  input  wire logic                         tlast,
  input  wire radio_sink_pkg::sec_user_t    tuser,
  output logic                              tready,

  // ------------------------------
  // control
  // ------------------------------
  input  wire radio_sink_pkg::slot_t        slot,
  input  wire logic                         enable,
  // tie high for normal use, toggled from outside to test back-pressure
  input  wire logic                         drive_tready,

  // ------------------------------
  // status
  // ------------------------------
  output logic                              status,
  output logic                              error_seen,
  output logic                              tlast_seen,
  output radio_sink_pkg::err_cnt_t          data_error_count,
  output radio_sink_pkg::pkt_cnt_t          tlast_count,
  output radio_sink_pkg::pkt_cnt_t          symbol_count
);

  // accepted beats, one cycle after the stream edge
  sink_beat_if    beat_link ();
  // judged beats, one more cycle on
  check_result_if result_link ();

  // input side
  sink_beat_capture u_capture (
    .s_sink_aclk  (s_sink_aclk),
    .rst          (rst),
    .enable       (enable),
    .tdata        (tdata),
    .tkeep        (tkeep),
    .tvalid       (tvalid),
    .tlast        (tlast),
    .tuser        (tuser),
    .tready       (tready),
    .slot         (slot),
    .drive_tready (drive_tready),
    .beat_bus     (beat_link.beat_out)
  );

  // pattern lock and compare
  pattern_checker u_checker (
    .s_sink_aclk (s_sink_aclk),
    .rst         (rst),
    .enable      (enable),
    .beat_bus    (beat_link.beat_in),
    .result_bus  (result_link.result_out)
  );

  // output side, counts valid 3 cycles after the accepting edge
  sink_status u_status (
    .s_sink_aclk      (s_sink_aclk),
    .rst              (rst),
    .enable           (enable),
    .result_bus       (result_link.result_in),
    .status           (status),
    .error_seen       (error_seen),
    .tlast_seen       (tlast_seen),
    .data_error_count (data_error_count),
    .tlast_count      (tlast_count),
    .symbol_count     (symbol_count)
  );

endmodule

`default_nettype wire

/* logic/sink_beat_capture.sv */
// sink_beat_capture: stream accept, beat registers with slot, sosy decode
`timescale 1ns/1ps
`default_nettype none

`include "radio_sink_defs.svh"

module sink_beat_capture (
  input  wire logic                         s_sink_aclk,
  input  wire logic                         rst,
  input  wire logic                         enable,

  // sample stream from the de-framer
  input  wire radio_sink_pkg::sample_word_t tdata,
  input  wire radio_sink_pkg::byte_keep_t   tkeep,
  input  wire logic                         tvalid,
  input  wire logic                         tlast,
  input  wire radio_sink_pkg::sec_user_t    tuser,
  output logic                              tready,

  // slot number and external ready pattern
  input  wire radio_sink_pkg::slot_t        slot,
  input  wire logic                         drive_tready,

  sink_beat_if.beat_out                     beat_bus
);

  // ------------------------------
  // handshake
  // ------------------------------

  logic accept;

  // back-pressure comes only from outside, no internal stall
  assign tready = drive_tready;

  // a beat transfers on an edge with valid and ready both high
  assign accept = tvalid && tready;

  // ------------------------------
  // beat strobe
  // ------------------------------

  // strobe is high the cycle after the accepting edge
  // enable low behaves like reset and keeps the strobe quiet
  always_ff @(posedge s_sink_aclk) begin
    if (rst || !enable) begin
      beat_bus.beat <= 1'b0;
    end else begin
      beat_bus.beat <= accept;
    end
  end

  // ------------------------------
  // payload
  // ------------------------------

  // loaded only on accepted beats so the checker sees held values
  // between strobes
  always_ff @(posedge s_sink_aclk) begin
    if (accept) begin
      beat_bus.data <= tdata;
      beat_bus.keep <= tkeep;
      beat_bus.last <= tlast;
      // only sosy is needed from tuser here
      beat_bus.sosy <= tuser[`RS_SOSY_BIT];
      // slot travels with its beat, later slot changes do not affect it
      beat_bus.slot <= slot;
    end
  end

endmodule

`default_nettype wire

/* logic/sink_status.sv */
// sink_status: saturating error counter, tlast and symbol counters, status flags
`timescale 1ns/1ps
`default_nettype none

`include "radio_sink_defs.svh"

module sink_status (
  input  wire logic                   s_sink_aclk,
  input  wire logic                   rst,
  input  wire logic                   enable,

  // judged beats from the checker
  check_result_if.result_in           result_bus,

  // status towards the outside
  output logic                        status,
  output logic                        error_seen,
  output logic                        tlast_seen,
  output radio_sink_pkg::err_cnt_t    data_error_count,
  output radio_sink_pkg::pkt_cnt_t    tlast_count,
  output radio_sink_pkg::pkt_cnt_t    symbol_count
);

  import radio_sink_pkg::*;

  err_cnt_t err_next;
  logic     last_done;
  logic     sosy_done;

  // ------------------------------
  // error count
  // ------------------------------

  // next value of the error counter
  // stops counting once the top bit is set
  always_comb begin
    err_next = data_error_count;
    if (result_bus.done && result_bus.mismatch && !data_error_count[`RS_ERR_W-1]) begin
      err_next = data_error_count + err_cnt_t'(1);
    end
  end

  // only judged beats carry meaningful last and sosy
  assign last_done = result_bus.done && result_bus.last;
  assign sosy_done = result_bus.done && result_bus.sosy;

  // ------------------------------
  // registers
  // ------------------------------

  always_ff @(posedge s_sink_aclk) begin
    if (rst || !enable) begin
      status           <= 1'b0;
      error_seen       <= 1'b0;
      tlast_seen       <= 1'b0;
      data_error_count <= '0;
      tlast_count      <= '0;
      symbol_count     <= '0;
    end else begin
      // lock status one cycle behind the checker
      status           <= result_bus.locked;
      data_error_count <= err_next;
      // flag taken from the same next value so it lines up with the count
      error_seen       <= (err_next != '0);
      // one cycle pulse per packet end
      tlast_seen       <= last_done;
      // both counts wrap at 256
      if (last_done) begin
        tlast_count <= tlast_count + pkt_cnt_t'(1);
      end
      if (sosy_done) begin
        symbol_count <= symbol_count + pkt_cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the radio sink testbench with Verilator.
# The run passes only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

# assertion failures are counted by the testbench, so let the run go on past them
rm -f sim.log \
  && verilator --binary --timing --assert -f src.f \
       --top-module radio_sink_tb -o radio_sink_sim \
  && ./obj_dir/radio_sink_sim +verilator+error+limit+1000 2>&1 | tee sim.log \
  && grep -qx ">>> PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0

/* src.f */
+incdir+logic
logic/radio_sink_pkg.sv
logic/radio_sink_ifs.sv
logic/sink_beat_capture.sv
logic/pattern_checker.sv
logic/sink_status.sv
logic/radio_sink_top.sv
tests/radio_sink_asserts.sv
tests/radio_sink_tb.sv

/* tests/radio_sink_asserts.sv */
// radio_sink_asserts: concurrent port checks and their bind into radio_sink_top
`timescale 1ns/1ps
`default_nettype none

module radio_sink_asserts (
  input wire logic                     s_sink_aclk,
  input wire logic                     rst,
  input wire logic                     enable,
  input wire logic                     drive_tready,
  input wire logic                     tready,
  input wire logic                     status,
  input wire logic                     error_seen,
  input wire logic                     tlast_seen,
  input wire radio_sink_pkg::err_cnt_t data_error_count,
  input wire radio_sink_pkg::pkt_cnt_t tlast_count,
  input wire radio_sink_pkg::pkt_cnt_t symbol_count
);

  // number of failed assertions
  int unsigned fail_count = 0;

  // ------------------------------
  // handshake and flags
  // ------------------------------

  // ready is a straight copy of the external level
  a_tready_follows: assert property (@(posedge s_sink_aclk) tready == drive_tready)
    else begin
      fail_count++;
      $error("tready differs from drive_tready");
    end

  // flag tracks a nonzero error count
  a_error_flag: assert property (@(posedge s_sink_aclk) disable iff (rst)
    error_seen == (data_error_count != '0))
    else begin
      fail_count++;
      $error("error_seen does not match data_error_count");
    end

  // packet end indication never stretches
  a_tlast_pulse: assert property (@(posedge s_sink_aclk) disable iff (rst)
    tlast_seen |=> !tlast_seen)
    else begin
      fail_count++;
      $error("tlast_seen high for more than one cycle");
    end

  // ------------------------------
  // clear behavior
  // ------------------------------

  // reset and enable low both clear the outputs
  a_clear: assert property (@(posedge s_sink_aclk) (rst || !enable) |=>
    (!status && !error_seen && !tlast_seen && data_error_count == '0 &&
     tlast_count == '0 && symbol_count == '0))
    else begin
      fail_count++;
      $error("outputs not cleared after reset or enable low");
    end

endmodule

bind radio_sink_top radio_sink_asserts u_asserts (
  .s_sink_aclk      (s_sink_aclk),
  .rst              (rst),
  .enable           (enable),
  .drive_tready     (drive_tready),
  .tready           (tready),
  .status           (status),
  .error_seen       (error_seen),
  .tlast_seen       (tlast_seen),
  .data_error_count (data_error_count),
  .tlast_count      (tlast_count),
  .symbol_count     (symbol_count)
);

`default_nettype wire

/* tests/radio_sink_tb.sv */
// radio_sink_tb: clock, reset, random pattern stream with corruptions, reference model, checks
`timescale 1ns/1ps
`default_nettype none

`include "radio_sink_defs.svh"

module radio_sink_tb;
  import radio_sink_pkg::*;

  logic         s_sink_aclk = 1'b0;
  logic         rst;
  sample_word_t tdata;
  byte_keep_t   tkeep;
  logic         tvalid;
  logic         tlast;
  sec_user_t    tuser;
  logic         tready;
  slot_t        slot;
  logic         enable;
  logic         drive_tready;
  logic         status;
  logic         error_seen;
  logic         tlast_seen;
  err_cnt_t     data_error_count;
  pkt_cnt_t     tlast_count;
  pkt_cnt_t     symbol_count;

  integer       seed = 32'h6479_4346;
  int unsigned  cycle = 0;
  int unsigned  errors = 0;
  int unsigned  checks = 0;
  // reference model of lock, running count and status counters
  logic         m_lock;
  pat_cnt_t     m_cnt;
  err_cnt_t     m_err;
  pkt_cnt_t     m_tlast;
  pkt_cnt_t     m_sym;
  // accept cycles of last beats still owed a tlast_seen pulse
  int unsigned  last_q[$];
  // stream generator state
  pat_cnt_t     gen_cnt;
  logic         use_bp;
  int           bad_pct;

  // 4 ns period
  always #2 s_sink_aclk = ~s_sink_aclk;

  radio_sink_top dut (
    .s_sink_aclk      (s_sink_aclk),
    .rst              (rst),
    .tdata            (tdata),
    .tkeep            (tkeep),
    .tvalid           (tvalid),
    .tlast            (tlast),
    .tuser            (tuser),
    .tready           (tready),
    .slot             (slot),
    .enable           (enable),
    .drive_tready     (drive_tready),
    .status           (status),
    .error_seen       (error_seen),
    .tlast_seen       (tlast_seen),
    .data_error_count (data_error_count),
    .tlast_count      (tlast_count),
    .symbol_count     (symbol_count)
  );

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // ------------------------------
  // reference model
  // ------------------------------

  task automatic model_clear();
    m_lock  = 1'b0;
    m_cnt   = '0;
    m_err   = '0;
    m_tlast = '0;
    m_sym   = '0;
  endtask

  // hunt seeds the count from the beat, track compares bytes under keep
  task automatic model_beat(input sample_word_t d, input byte_keep_t k, input slot_t s,
                            input logic l, input logic sy);
    sample_word_t exp_w;
    logic         bad;
    bad   = 1'b0;
    exp_w = {`RS_MARK_NIBBLE, s, `RS_MARK_NIBBLE, m_cnt, m_cnt, m_cnt};
    if (!m_lock) begin
      m_cnt  = d[15:0] + 16'd1;
      m_lock = 1'b1;
    end else begin
      for (int i = 0; i < 8; i++) begin
        if (k[i] && (d[8*i +: 8] != exp_w[8*i +: 8])) begin
          bad = 1'b1;
        end
      end
      if (bad) begin
        // count stays put, lock drops
        m_lock = 1'b0;
        if (!m_err[`RS_ERR_W-1]) begin
          m_err++;
        end
      end else begin
        m_cnt++;
      end
    end
    if (l) begin
      m_tlast++;
      last_q.push_back(cycle);
    end
    if (sy) begin
      m_sym++;
    end
  endtask

  // ------------------------------
  // cycle step and pulse monitor
  // ------------------------------

  // every edge passes through here
  // tlast_seen is due 3 edges after accept
  task automatic tick();
    @(posedge s_sink_aclk);
    cycle++;
    if (tlast_seen === 1'b1) begin
      if (last_q.size() == 0) begin
        errors++;
        $display("tlast_seen pulsed at %0t without an accepted last beat", $time);
      end else begin
        check_val("tlast_seen cycle", last_q.pop_front() + 32'd3, cycle);
      end
    end
  endtask

  // hold the beat until an edge with ready high
  task automatic send_beat(input sample_word_t d, input byte_keep_t k, input logic l,
                           input sec_user_t u);
    int unsigned waited;
    logic        taken;
    waited = 0;
    taken  = 1'b0;
    tvalid <= 1'b1;
    tdata  <= d;
    tkeep  <= k;
    tlast  <= l;
    tuser  <= u;
    while (!taken && waited < 64) begin
      tick();
      // ready must follow the external level combinationally
      check_val("tready", 32'(drive_tready), 32'(tready));
      taken = tready;
      // ready low about one edge in four under back-pressure
      drive_tready <= use_bp ? (($random(seed) % 4) != 0) : 1'b1;
      waited++;
    end
    if (!taken) begin
      $display("timeout: beat not accepted within 64 cycles at %0t", $time);
      $display(">>> FAIL");
      $finish;
    end else begin
      model_beat(d, k, slot, l, u[`RS_SOSY_BIT]);
    end
  endtask

  // one packet of pattern beats with a fresh slot
  task automatic send_packet(input int n_beats);
    sample_word_t d;
    byte_keep_t   k;
    sec_user_t    u;
    slot_t        s;
    int           pos;
    s = slot_t'($random(seed));
    slot <= s;
    for (int b = 0; b < n_beats; b++) begin
      d = {`RS_MARK_NIBBLE, s, `RS_MARK_NIBBLE, gen_cnt, gen_cnt, gen_cnt};
      k = byte_keep_t'($random(seed));
      u = sec_user_t'($random(seed));
      // at most one corrupted byte per beat
      // its keep bit decides whether it counts
      if (({$random(seed)} % 100) < bad_pct) begin
        pos = {$random(seed)} % 8;
        d[8*pos +: 8] = d[8*pos +: 8] ^ (8'($random(seed)) | 8'h01);
      end
      send_beat(d, k, b == n_beats - 1, u);
      gen_cnt++;
    end
  endtask

  // idle long enough for status totals to settle, then compare
  task automatic settle_and_check(input int gap);
    tvalid       <= 1'b0;
    tlast        <= 1'b0;
    drive_tready <= 1'b1;
    repeat (gap) tick();
    check_val("status", 32'(m_lock), 32'(status));
    check_val("error_seen", 32'(m_err != '0), 32'(error_seen));
    check_val("data_error_count", 32'(m_err), 32'(data_error_count));
    check_val("tlast_count", 32'(m_tlast), 32'(tlast_count));
    check_val("symbol_count", 32'(m_sym), 32'(symbol_count));
    check_val("pending tlast_seen pulses", 32'd0, last_q.size());
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    rst          <= 1'b1;
    enable       <= 1'b1;
    drive_tready <= 1'b1;
    tvalid       <= 1'b0;
    tdata        <= '0;
    tkeep        <= '0;
    tlast        <= 1'b0;
    tuser        <= '0;
    slot         <= '0;
    model_clear();
    gen_cnt = pat_cnt_t'($random(seed));
    use_bp  = 1'b0;
    bad_pct = 0;
    repeat (16) tick();
    rst <= 1'b0;
    tick();
    // clean stream locks and stays error free
    repeat (4) send_packet(2 + {$random(seed)} % 8);
    settle_and_check(4);
    check_val("status on clean stream", 32'd1, 32'(status));
    check_val("errors on clean stream", 32'd0, 32'(data_error_count));
    // corrupted bytes, slot changes per packet
    bad_pct = 20;
    repeat (8) begin
      send_packet(2 + {$random(seed)} % 8);
      settle_and_check(4 + {$random(seed)} % 3);
    end
    // back-pressure with back to back packets
    use_bp = 1'b1;
    repeat (6) send_packet(2 + {$random(seed)} % 8);
    settle_and_check(5);
    // enable low clears everything, next packet relocks from its own data
    enable <= 1'b0;
    model_clear();
    settle_and_check(3);
    check_val("tlast_seen while disabled", 32'd0, 32'(tlast_seen));
    enable  <= 1'b1;
    bad_pct = 0;
    gen_cnt = pat_cnt_t'($random(seed));
    send_packet(6);
    settle_and_check(5);
    errors += dut.u_asserts.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut.u_asserts.fail_count);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
